// File: design/tlb_params.svh
// AXI TLB parameters
`ifndef TLB_PARAMS_SVH
`define TLB_PARAMS_SVH

// bus widths
`define TLB_ADDR_W        64
`define TLB_PAGE_BITS     12
`define TLB_VPN_W         52
`define TLB_ID_W          16
`define TLB_DATA_W        512

// page-table layout
`define TLB_PTES_PER_LINE 8
`define TLB_PTE_INDEX_W   23
`define TLB_PTE_TAG_W     36
`define TLB_PTE_RPN_W     24
`define TLB_APP_ID_W      2

// arsize of one 64-byte table line
`define TLB_LINE_SIZE     3'd6

`define TLB_RESP_OKAY     2'b00
`define TLB_RESP_SLVERR   2'b10

`define TLB_META_DEPTH    2
`define TLB_RDATA_DEPTH   16

`endif

// File: design/tlb_pkg.sv
// AXI TLB shared types
`include "tlb_params.svh"

package tlb_pkg;

	typedef logic [`TLB_VPN_W-1:0]     page_num_t;
	typedef logic [`TLB_PAGE_BITS-1:0] page_off_t;
	typedef logic [`TLB_ID_W-1:0]      axi_id_t;
	typedef logic [7:0]                axi_len_t;
	typedef logic [2:0]                axi_size_t;
	typedef logic [1:0]                axi_resp_t;
	typedef logic [`TLB_DATA_W-1:0]    axi_data_t;

	// one page-table entry, eight per fetched line
	typedef struct packed {
		logic [`TLB_APP_ID_W-1:0]  app_id;
		logic [`TLB_PTE_TAG_W-1:0] tag;
		logic [`TLB_PTE_RPN_W-1:0] rpn;
		logic                      writable;
		logic                      present;
	} pte_t;

	// request fields kept while the page is translated
	typedef struct packed {
		axi_id_t   id;
		axi_len_t  len;
		axi_size_t size;
		page_off_t off;
	} ar_meta_t;

	typedef struct packed {
		page_num_t page;
		logic      ok;
	} xlate_t;

	typedef struct packed {
		axi_id_t id;
		logic    translated;
	} ret_meta_t;

	typedef struct packed {
		axi_data_t data;
		axi_resp_t resp;
		logic      last;
	} rbeat_t;

endpackage

// File: design/sync_fifo.sv
// show-ahead synchronous FIFO
`timescale 1ns/100ps

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 2
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     wr_en,
	input  payload_t wr_data,
	input  logic     rd_en,
	output payload_t rd_data,
	output logic     full,
	output logic     empty
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_wr, do_rd;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full    = (count == CNT_W'(DEPTH));
	assign empty   = (count == '0);
	assign do_wr   = wr_en && !full;
	assign do_rd   = rd_en && !empty;
	// head entry is always on the output
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_rd) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			count <= count + CNT_W'(do_wr) - CNT_W'(do_rd);
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (rst) wr_en |-> !full)
		else $error("write to full FIFO");
	a_no_underflow: assert property (@(posedge clk) disable iff (rst) rd_en |-> !empty)
		else $error("read from empty FIFO");

endmodule

// File: design/read_mgr.sv
// virtual read channel manager
`timescale 1ns/100ps
`include "tlb_params.svh"

module read_mgr import tlb_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  axi_id_t                ar_id,
	input  logic [`TLB_ADDR_W-1:0] ar_addr,
	input  axi_len_t               ar_len,
	input  axi_size_t              ar_size,
	input  logic                   ar_valid,
	output logic                   ar_ready,
	output axi_id_t                r_id,
	output axi_data_t              r_data,
	output axi_resp_t              r_resp,
	output logic                   r_last,
	output logic                   r_valid,
	input  logic                   r_ready,
	output page_num_t              xreq_page,
	output logic                   xreq_valid,
	input  logic                   xreq_ready,
	input  page_num_t              xresp_page,
	input  logic                   xresp_ok,
	input  logic                   xresp_valid,
	output logic                   xresp_ready,
	output axi_id_t                mar_id,
	output logic [`TLB_ADDR_W-1:0] mar_addr,
	output axi_len_t               mar_len,
	output axi_size_t              mar_size,
	output logic                   mar_valid,
	input  logic                   mar_ready,
	input  axi_id_t                mr_id,
	input  axi_data_t              mr_data,
	input  axi_resp_t              mr_resp,
	input  logic                   mr_last,
	input  logic                   mr_valid,
	output logic                   mr_ready
);
	ar_meta_t  am_in, am_out;
	page_num_t pn_out;
	xlate_t    xl_in, xl_out;
	ret_meta_t ret_in, ret_out;
	rbeat_t    beat_in, beat_out;
	logic      am_full, am_empty, pn_full, pn_empty, xl_full, xl_empty;
	logic      ret_full, ret_empty, beat_full, beat_empty;
	logic      ar_fire, pair_valid, pair_fire, r_fire;

	// split each read into metadata and page number
	assign ar_ready = !am_full && !pn_full;
	assign ar_fire  = ar_valid && ar_ready;
	assign am_in    = '{id: ar_id, len: ar_len, size: ar_size,
		off: ar_addr[`TLB_PAGE_BITS-1:0]};

	sync_fifo #(.payload_t(ar_meta_t), .DEPTH(`TLB_META_DEPTH)) u_ar_meta_fifo (
		.clk(clk), .rst(rst), .wr_en(ar_fire), .wr_data(am_in),
		.rd_en(pair_fire), .rd_data(am_out), .full(am_full), .empty(am_empty));

	sync_fifo #(.payload_t(page_num_t), .DEPTH(`TLB_META_DEPTH)) u_page_fifo (
		.clk(clk), .rst(rst), .wr_en(ar_fire),
		.wr_data(ar_addr[`TLB_ADDR_W-1:`TLB_PAGE_BITS]),
		.rd_en(xreq_valid && xreq_ready), .rd_data(pn_out), .full(pn_full), .empty(pn_empty));

	assign xreq_page  = pn_out;
	assign xreq_valid = !pn_empty;

	// translation results, in request order
	assign xresp_ready = !xl_full;
	assign xl_in       = '{page: xresp_page, ok: xresp_ok};

	sync_fifo #(.payload_t(xlate_t), .DEPTH(`TLB_META_DEPTH)) u_xlate_fifo (
		.clk(clk), .rst(rst), .wr_en(xresp_valid && xresp_ready), .wr_data(xl_in),
		.rd_en(pair_fire), .rd_data(xl_out), .full(xl_full), .empty(xl_empty));

	// pair result with metadata; a failed translation skips memory
	assign pair_valid = !am_empty && !xl_empty && !ret_full;
	assign pair_fire  = pair_valid && (!xl_out.ok || mar_ready);
	assign mar_valid  = pair_valid && xl_out.ok;
	assign mar_id     = '0;
	assign mar_addr   = {xl_out.page, am_out.off};
	assign mar_len    = am_out.len;
	assign mar_size   = am_out.size;
	assign ret_in     = '{id: am_out.id, translated: xl_out.ok};

	sync_fifo #(.payload_t(ret_meta_t), .DEPTH(`TLB_META_DEPTH)) u_ret_meta_fifo (
		.clk(clk), .rst(rst), .wr_en(pair_fire), .wr_data(ret_in),
		.rd_en(r_fire && r_last), .rd_data(ret_out), .full(ret_full), .empty(ret_empty));

	assign mr_ready = !beat_full;
	assign beat_in  = '{data: mr_data, resp: mr_resp, last: mr_last};

	sync_fifo #(.payload_t(rbeat_t), .DEPTH(`TLB_RDATA_DEPTH)) u_rdata_fifo (
		.clk(clk), .rst(rst), .wr_en(mr_valid && mr_ready), .wr_data(beat_in),
		.rd_en(r_fire && ret_out.translated), .rd_data(beat_out),
		.full(beat_full), .empty(beat_empty));

	// memory beats for a hit, one SLVERR beat for a fault
	assign r_valid = !ret_empty && (!ret_out.translated || !beat_empty);
	assign r_id    = ret_out.id;
	assign r_data  = ret_out.translated ? beat_out.data : '0;
	assign r_resp  = ret_out.translated ? beat_out.resp : `TLB_RESP_SLVERR;
	assign r_last  = !ret_out.translated || beat_out.last;
	assign r_fire  = r_valid && r_ready;

	a_r_hold: assert property (@(posedge clk) disable iff (rst)
		r_valid && !r_ready |=> r_valid && $stable(r_id))
		else $error("R beat dropped under back-pressure");
	// the mux strips its tag, so our reads come back with ID 0
	a_mr_id: assert property (@(posedge clk) disable iff (rst) mr_valid |-> mr_id == '0)
		else $error("unexpected ID on returned beat");

endmodule

// File: design/pte_walker.sv
// page-table walker
`timescale 1ns/100ps
`include "tlb_params.svh"

module pte_walker import tlb_pkg::*; #(
	parameter logic [`TLB_APP_ID_W-1:0] APP_ID = '0
) (
	input  logic                   clk,
	input  logic                   rst,
	input  page_num_t              xreq_page,
	input  logic                   xreq_valid,
	output logic                   xreq_ready,
	output page_num_t              xresp_page,
	output logic                   xresp_ok,
	output logic                   xresp_valid,
	input  logic                   xresp_ready,
	output logic [`TLB_ADDR_W-1:0] war_addr,
	output logic                   war_valid,
	input  logic                   war_ready,
	input  axi_data_t              wr_data,
	input  logic                   wr_valid,
	output logic                   wr_ready
);
	// byte offset of a line, log2 of its size
	localparam int LINE_OFF_W = `TLB_LINE_SIZE;
	localparam int PTE_W      = $bits(pte_t);

	page_num_t                     pend_out;
	logic [`TLB_ADDR_W-1:0]        line_addr_in;
	axi_data_t                     line_out;
	xlate_t                        res_in, res_out;
	logic [`TLB_PTES_PER_LINE-1:0] match;
	logic                          pend_full, pend_empty, la_full, la_empty;
	logic                          line_full, line_empty, res_full, res_empty;
	logic                          req_fire, check_fire;

	// every request is queued twice
	assign xreq_ready   = !pend_full && !la_full;
	assign req_fire     = xreq_valid && xreq_ready;
	assign line_addr_in = {{(`TLB_ADDR_W - `TLB_PTE_INDEX_W - LINE_OFF_W){1'b0}},
		xreq_page[`TLB_PTE_INDEX_W-1:0], {LINE_OFF_W{1'b0}}};

	sync_fifo #(.payload_t(page_num_t), .DEPTH(`TLB_META_DEPTH)) u_pend_fifo (
		.clk(clk), .rst(rst), .wr_en(req_fire), .wr_data(xreq_page),
		.rd_en(check_fire), .rd_data(pend_out), .full(pend_full), .empty(pend_empty));

	sync_fifo #(.payload_t(logic [`TLB_ADDR_W-1:0]), .DEPTH(`TLB_META_DEPTH)) u_addr_fifo (
		.clk(clk), .rst(rst), .wr_en(req_fire), .wr_data(line_addr_in),
		.rd_en(war_valid && war_ready), .rd_data(war_addr), .full(la_full), .empty(la_empty));

	// single-beat line fetch; ID, length and size are added by the mux
	assign war_valid = !la_empty;
	assign wr_ready  = !line_full;

	sync_fifo #(.payload_t(axi_data_t), .DEPTH(`TLB_META_DEPTH)) u_line_fifo (
		.clk(clk), .rst(rst), .wr_en(wr_valid && wr_ready), .wr_data(wr_data),
		.rd_en(check_fire), .rd_data(line_out), .full(line_full), .empty(line_empty));

	// all eight entries checked at once, lowest match wins
	always_comb begin
		pte_t pte;
		res_in = '{page: '0, ok: 1'b0};
		for (int i = 0; i < `TLB_PTES_PER_LINE; i++) begin
			pte = line_out[i*PTE_W +: PTE_W];
			match[i] = pte.present
				&& (pend_out[`TLB_VPN_W-1:`TLB_PTE_TAG_W] == '0)
				&& (pend_out[`TLB_PTE_TAG_W-1:0] == pte.tag)
				&& (pte.app_id == APP_ID);
			if (match[i] && !res_in.ok) begin
				res_in.page = page_num_t'(pte.rpn);
			end
			res_in.ok = res_in.ok || match[i];
		end
	end

	assign check_fire = !pend_empty && !line_empty && !res_full;

	sync_fifo #(.payload_t(xlate_t), .DEPTH(`TLB_META_DEPTH)) u_result_fifo (
		.clk(clk), .rst(rst), .wr_en(check_fire), .wr_data(res_in),
		.rd_en(xresp_valid && xresp_ready), .rd_data(res_out),
		.full(res_full), .empty(res_empty));

	assign xresp_valid = !res_empty;
	assign xresp_page  = res_out.page;
	assign xresp_ok    = res_out.ok;

endmodule

// File: design/phys_read_mux.sv
// physical read port sharing
`timescale 1ns/100ps
`include "tlb_params.svh"

module phys_read_mux import tlb_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  axi_id_t                rm_ar_id,
	input  logic [`TLB_ADDR_W-1:0] rm_ar_addr,
	input  axi_len_t               rm_ar_len,
	input  axi_size_t              rm_ar_size,
	input  logic                   rm_ar_valid,
	output logic                   rm_ar_ready,
	output axi_id_t                rm_r_id,
	output axi_data_t              rm_r_data,
	output axi_resp_t              rm_r_resp,
	output logic                   rm_r_last,
	output logic                   rm_r_valid,
	input  logic                   rm_r_ready,
	input  logic [`TLB_ADDR_W-1:0] tw_ar_addr,
	input  logic                   tw_ar_valid,
	output logic                   tw_ar_ready,
	output axi_data_t              tw_r_data,
	output logic                   tw_r_valid,
	input  logic                   tw_r_ready,
	output axi_id_t                par_id,
	output logic [`TLB_ADDR_W-1:0] par_addr,
	output axi_len_t               par_len,
	output axi_size_t              par_size,
	output logic                   par_valid,
	input  logic                   par_ready,
	input  axi_id_t                pr_id,
	input  axi_data_t              pr_data,
	input  axi_resp_t              pr_resp,
	input  logic                   pr_last,
	input  logic                   pr_valid,
	output logic                   pr_ready
);
	logic [7:0] tw_pending, rm_pending;

	// walker has fixed priority; ID bit 0 tags the source
	assign par_valid   = tw_ar_valid || rm_ar_valid;
	assign par_id      = tw_ar_valid ? '0 : {rm_ar_id[`TLB_ID_W-2:0], 1'b1};
	assign par_addr    = tw_ar_valid ? tw_ar_addr : rm_ar_addr;
	assign par_len     = tw_ar_valid ? '0 : rm_ar_len;
	assign par_size    = tw_ar_valid ? `TLB_LINE_SIZE : rm_ar_size;
	assign tw_ar_ready = par_ready;
	assign rm_ar_ready = par_ready && !tw_ar_valid;

	// return beats steered by the tag
	assign tw_r_data  = pr_data;
	assign tw_r_valid = pr_valid && !pr_id[0];
	assign rm_r_id    = {1'b0, pr_id[`TLB_ID_W-1:1]};
	assign rm_r_data  = pr_data;
	assign rm_r_resp  = pr_resp;
	assign rm_r_last  = pr_last;
	assign rm_r_valid = pr_valid && pr_id[0];
	assign pr_ready   = pr_id[0] ? rm_r_ready : tw_r_ready;

	// outstanding bursts per source, only watched by the check below
	always_ff @(posedge clk) begin
		if (rst) begin
			tw_pending <= '0;
			rm_pending <= '0;
		end else begin
			tw_pending <= tw_pending + 8'(tw_ar_valid && tw_ar_ready)
				- 8'(tw_r_valid && tw_r_ready);
			rm_pending <= rm_pending + 8'(rm_ar_valid && rm_ar_ready)
				- 8'(rm_r_valid && rm_r_ready && pr_last);
		end
	end

	a_tag_known: assert property (@(posedge clk) disable iff (rst)
		pr_valid |-> (pr_id[0] ? rm_pending != '0 : tw_pending != '0))
		else $error("read beat for a source with nothing outstanding");

endmodule

// File: design/axi_tlb_top.sv
// AXI read address translation
`timescale 1ns/100ps
`include "tlb_params.svh"

module axi_tlb_top import tlb_pkg::*; #(
	parameter logic [`TLB_APP_ID_W-1:0] APP_ID = '0
) (
	input  logic                   clk,
	input  logic                   rst,
	input  axi_id_t                ar_id,
	input  logic [`TLB_ADDR_W-1:0] ar_addr,
	input  axi_len_t               ar_len,
	input  axi_size_t              ar_size,
	input  logic                   ar_valid,
	output logic                   ar_ready,
	output axi_id_t                r_id,
	output axi_data_t              r_data,
	output axi_resp_t              r_resp,
	output logic                   r_last,
	output logic                   r_valid,
	input  logic                   r_ready,
	output axi_id_t                par_id,
	output logic [`TLB_ADDR_W-1:0] par_addr,
	output axi_len_t               par_len,
	output axi_size_t              par_size,
	output logic                   par_valid,
	input  logic                   par_ready,
	input  axi_id_t                pr_id,
	input  axi_data_t              pr_data,
	input  axi_resp_t              pr_resp,
	input  logic                   pr_last,
	input  logic                   pr_valid,
	output logic                   pr_ready
);
	// translation channel
	page_num_t              xreq_page, xresp_page;
	logic                   xreq_valid, xreq_ready, xresp_ok, xresp_valid, xresp_ready;

	// read manager side of the physical port
	axi_id_t                mar_id, mr_id;
	logic [`TLB_ADDR_W-1:0] mar_addr;
	axi_len_t               mar_len;
	axi_size_t              mar_size;
	axi_data_t              mr_data;
	axi_resp_t              mr_resp;
	logic                   mar_valid, mar_ready, mr_last, mr_valid, mr_ready;

	// walker side of the physical port
	logic [`TLB_ADDR_W-1:0] war_addr;
	axi_data_t              wr_data;
	logic                   war_valid, war_ready, wr_valid, wr_ready;

	read_mgr u_read_mgr (.*);

	pte_walker #(.APP_ID(APP_ID)) u_pte_walker (.*);

	phys_read_mux u_phys_read_mux (
		.clk(clk), .rst(rst),
		.rm_ar_id(mar_id), .rm_ar_addr(mar_addr), .rm_ar_len(mar_len),
		.rm_ar_size(mar_size), .rm_ar_valid(mar_valid), .rm_ar_ready(mar_ready),
		.rm_r_id(mr_id), .rm_r_data(mr_data), .rm_r_resp(mr_resp),
		.rm_r_last(mr_last), .rm_r_valid(mr_valid), .rm_r_ready(mr_ready),
		.tw_ar_addr(war_addr), .tw_ar_valid(war_valid), .tw_ar_ready(war_ready),
		.tw_r_data(wr_data), .tw_r_valid(wr_valid), .tw_r_ready(wr_ready),
		.par_id(par_id), .par_addr(par_addr), .par_len(par_len),
		.par_size(par_size), .par_valid(par_valid), .par_ready(par_ready),
		.pr_id(pr_id), .pr_data(pr_data), .pr_resp(pr_resp),
		.pr_last(pr_last), .pr_valid(pr_valid), .pr_ready(pr_ready));

endmodule

// File: verif/phys_mem_model.sv
// physical memory model
`timescale 1ns/100ps
`include "tlb_params.svh"

module phys_mem_model #(
	parameter int LATENCY = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`TLB_ID_W-1:0]   par_id,
	input  logic [`TLB_ADDR_W-1:0] par_addr,
	input  logic [7:0]             par_len,
	input  logic                   par_valid,
	output logic                   par_ready,
	output logic [`TLB_ID_W-1:0]   pr_id,
	output logic [`TLB_DATA_W-1:0] pr_data,
	output logic [1:0]             pr_resp,
	output logic                   pr_last,
	output logic                   pr_valid,
	input  logic                   pr_ready
);
	// PTEs by entry index, which is the byte address over 8
	logic [63:0]            pte_mem [logic [63:0]];
	logic [`TLB_ID_W-1:0]   q_id [$];
	logic [`TLB_ADDR_W-1:0] q_addr [$];
	logic [7:0]             q_len [$];
	int                     q_due [$];
	int                     cycle;
	int                     beat;

	task automatic write_pte(input logic [63:0] index, input logic [63:0] value);
		pte_mem[index] = value;
	endtask

	// table lines below 2^29, patterned data everywhere else
	function automatic logic [`TLB_DATA_W-1:0] beat_data(input logic [63:0] addr, input int b);
		logic [`TLB_DATA_W-1:0] d;
		logic [63:0]            base;
		d = '0;
		base = addr >> 3;
		if ((addr >> (`TLB_PTE_INDEX_W + 6)) == 0) begin
			for (int i = 0; i < `TLB_PTES_PER_LINE; i++) begin
				if (pte_mem.exists(base + 64'(i))) begin
					d[i*64 +: 64] = pte_mem[base + 64'(i)];
				end
			end
		end else begin
			d = {(`TLB_DATA_W/64){addr + 64'(b) * 64}};
		end
		return d;
	endfunction

	initial begin
		par_ready = 1'b1;
		pr_valid  = 1'b0;
		pr_id     = '0;
		pr_data   = '0;
		pr_resp   = '0;
		pr_last   = 1'b0;
	end

	always @(posedge clk) begin
		if (rst) begin
			pr_valid <= 1'b0;
			cycle = 0;
			beat = 0;
		end else begin
			if (par_valid && par_ready) begin
				q_id.push_back(par_id);
				q_addr.push_back(par_addr);
				q_len.push_back(par_len);
				q_due.push_back(cycle + LATENCY);
			end
			if (pr_valid && pr_ready) begin
				if (beat == int'(q_len[0])) begin
					q_id.delete(0);
					q_addr.delete(0);
					q_len.delete(0);
					q_due.delete(0);
					beat = 0;
				end else begin
					beat++;
				end
			end
			// answers leave in request order after the fixed delay
			if (q_id.size() != 0 && q_due[0] <= cycle) begin
				pr_valid <= 1'b1;
				pr_id    <= q_id[0];
				pr_data  <= beat_data(q_addr[0], beat);
				pr_resp  <= `TLB_RESP_OKAY;
				pr_last  <= (beat == int'(q_len[0]));
			end else begin
				pr_valid <= 1'b0;
			end
			cycle++;
		end
	end

endmodule

// File: verif/tb_axi_tlb.sv
// AXI TLB read testbench
`timescale 1ns/100ps
`include "tlb_params.svh"

module tb_axi_tlb;
	localparam int CLK_HALF = 50;

	logic                   clk;
	logic                   rst;
	logic [`TLB_ID_W-1:0]   ar_id;
	logic [`TLB_ADDR_W-1:0] ar_addr;
	logic [7:0]             ar_len;
	logic [2:0]             ar_size;
	logic                   ar_valid, ar_ready;
	logic [`TLB_ID_W-1:0]   r_id;
	logic [`TLB_DATA_W-1:0] r_data;
	logic [1:0]             r_resp;
	logic                   r_last, r_valid, r_ready;
	logic [`TLB_ID_W-1:0]   par_id, pr_id;
	logic [`TLB_ADDR_W-1:0] par_addr;
	logic [7:0]             par_len;
	logic [2:0]             par_size;
	logic                   par_valid, par_ready;
	logic [`TLB_DATA_W-1:0] pr_data;
	logic [1:0]             pr_resp;
	logic                   pr_last, pr_valid, pr_ready;

	// requests from the trace, in issue order
	logic [`TLB_ID_W-1:0]   req_id [$];
	logic [`TLB_ADDR_W-1:0] req_addr [$];
	logic [7:0]             req_len [$];
	logic                   req_hit [$];
	logic [23:0]            req_rpn [$];
	logic [`TLB_ADDR_W-1:0] exp_par [$];
	logic [7:0]             exp_len [$];
	logic [`TLB_ADDR_W-1:0] exp_line [$];

	logic [31:0] rng = 32'hbc4c7678;
	logic        trace_loaded = 1'b0;
	int          errors = 0;
	int          checks = 0;
	int          n_done = 0;
	int          beat_cnt = 0;

	axi_tlb_top #(.APP_ID(2'd1)) u_dut (.*);

	phys_mem_model u_mem (.*);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// translated page joined to the virtual page offset
	function automatic logic [`TLB_ADDR_W-1:0] expected_phys(input logic [23:0] rpn,
			input logic [`TLB_ADDR_W-1:0] vaddr);
		return {{(`TLB_ADDR_W - `TLB_PTE_RPN_W - `TLB_PAGE_BITS){1'b0}}, rpn,
			vaddr[`TLB_PAGE_BITS-1:0]};
	endfunction

	task automatic load_trace();
		int          fd;
		string       line;
		logic [63:0] c0, c1, c2, c3, c4, c5;
		fd = $fopen("verif/tlb_trace.txt", "r");
		if (fd == 0) begin
			$display("cannot open trace file verif/tlb_trace.txt");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() == 0) continue;
			if (line.getc(0) == "P") begin
				// line index, slot, app ID, tag, real page, present
				if ($sscanf(line, "P %h %h %h %h %h %h", c0, c1, c2, c3, c4, c5) == 6) begin
					u_mem.write_pte(c0 * 8 + c1, {c2[1:0], c3[35:0], c4[23:0], 1'b0, c5[0]});
				end else begin
					$display("malformed PTE line in trace: %s", line);
					errors++;
				end
			end else if (line.getc(0) == "R") begin
				if ($sscanf(line, "R %h %h %h %h %h", c0, c1, c2, c3, c4) == 5) begin
					req_id.push_back(c0[`TLB_ID_W-1:0]);
					req_addr.push_back(c1);
					req_len.push_back(c2[7:0]);
					req_hit.push_back(c3[0]);
					req_rpn.push_back(c4[23:0]);
					// every read fetches the 64-byte table line of its page
					exp_line.push_back(64'({c1[`TLB_PAGE_BITS +: `TLB_PTE_INDEX_W], 6'b0}));
					if (c3[0]) begin
						exp_par.push_back(expected_phys(c4[23:0], c1));
						exp_len.push_back(c2[7:0]);
					end
				end else begin
					$display("malformed read line in trace: %s", line);
					errors++;
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic check_beat();
		logic [`TLB_ADDR_W-1:0] phys;
		logic [`TLB_DATA_W-1:0] exp_data;
		logic                   exp_last;
		if (n_done >= req_id.size()) begin
			$display("FAILED %0t ns: R beat with no outstanding request", $time);
			errors++;
			return;
		end
		exp_last = !req_hit[n_done] || (beat_cnt == int'(req_len[n_done]));
		checks++;
		if (r_id != req_id[n_done]) begin
			$display("FAILED %0t ns: r_id %h, expected %h", $time, r_id, req_id[n_done]);
			errors++;
		end
		if (r_last != exp_last) begin
			$display("FAILED %0t ns: r_last %b on beat %0d of ID %h", $time, r_last,
				beat_cnt, req_id[n_done]);
			errors++;
		end
		if (req_hit[n_done]) begin
			phys = expected_phys(req_rpn[n_done], req_addr[n_done]) + 64'(beat_cnt) * 64;
			exp_data = {(`TLB_DATA_W/64){phys}};
			if (r_resp != `TLB_RESP_OKAY) begin
				$display("FAILED %0t ns: r_resp %b on a hit, ID %h", $time, r_resp, r_id);
				errors++;
			end
			if (r_data != exp_data) begin
				$display("FAILED %0t ns: r_data word %h, expected %h", $time, r_data[63:0],
					phys);
				errors++;
			end
		end else if (r_resp != `TLB_RESP_SLVERR) begin
			$display("FAILED %0t ns: r_resp %b on a fault, ID %h", $time, r_resp, r_id);
			errors++;
		end
		if (exp_last) begin
			n_done++;
			beat_cnt = 0;
		end else begin
			beat_cnt++;
		end
	endtask

	// random R back-pressure
	always @(posedge clk) begin
		rng = xorshift32(rng);
		r_ready <= rng[0] | rng[1];
	end

	always @(posedge clk) begin
		if (!rst && r_valid && r_ready) begin
			check_beat();
		end
	end

	// every read on the physical port, table fetches and translated reads
	always @(posedge clk) begin
		if (!rst && par_valid && par_ready) begin
			checks++;
			if (par_size != `TLB_LINE_SIZE) begin
				$display("FAILED %0t ns: par_size %0d, expected %0d", $time, par_size,
					`TLB_LINE_SIZE);
				errors++;
			end
			if (par_id[0]) begin
				if (exp_par.size() == 0) begin
					$display("FAILED %0t ns: unexpected translated read at %h", $time,
						par_addr);
					errors++;
				end else begin
					if (par_id != 16'd1 || par_addr != exp_par[0] || par_len != exp_len[0]) begin
						$display("FAILED %0t ns: read ID %h addr %h len %h, expected 0001 %h %h",
							$time, par_id, par_addr, par_len, exp_par[0], exp_len[0]);
						errors++;
					end
					exp_par.delete(0);
					exp_len.delete(0);
				end
			end else if (exp_line.size() == 0) begin
				$display("FAILED %0t ns: unexpected table fetch at %h", $time, par_addr);
				errors++;
			end else begin
				if (par_id != '0 || par_addr != exp_line[0] || par_len != '0) begin
					$display("FAILED %0t ns: fetch ID %h addr %h len %h, expected 0000 %h 00",
						$time, par_id, par_addr, par_len, exp_line[0]);
					errors++;
				end
				exp_line.delete(0);
			end
		end
	end

	initial begin
		rst      = 1'b1;
		ar_valid = 1'b0;
		ar_id    = '0;
		ar_addr  = '0;
		ar_len   = '0;
		ar_size  = '0;
		r_ready  = 1'b0;
		load_trace();
		trace_loaded = 1'b1;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		checks++;
		if (r_valid || par_valid || !ar_ready || !pr_ready) begin
			$display("FAILED %0t ns: r_valid %b par_valid %b ar_ready %b pr_ready %b idle",
				$time, r_valid, par_valid, ar_ready, pr_ready);
			errors++;
		end
		for (int i = 0; i < req_id.size(); i++) begin
			ar_valid <= 1'b1;
			ar_id    <= req_id[i];
			ar_addr  <= req_addr[i];
			ar_len   <= req_len[i];
			// full-width 64-byte beats
			ar_size  <= `TLB_LINE_SIZE;
			@(posedge clk);
			while (!ar_ready) @(posedge clk);
		end
		ar_valid <= 1'b0;
		while (n_done < req_id.size()) @(posedge clk);
		repeat (4) @(posedge clk);
		if (exp_par.size() != 0 || exp_line.size() != 0) begin
			$display("%0d translated reads and %0d table fetches never reached memory",
				exp_par.size(), exp_line.size());
			errors++;
		end
		$display("errors: %0d, checks: %0d, reads done: %0d of %0d", errors, checks,
			n_done, req_id.size());
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin
		wait (trace_loaded);
		repeat (req_id.size() * 300 + 100) @(posedge clk);
		errors++;
		$display("timeout: reads still outstanding after %0d cycles", req_id.size() * 300 + 100);
		$display("errors: %0d, checks: %0d, reads done: %0d of %0d", errors, checks,
			n_done, req_id.size());
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: verif/tlb_trace.txt
# P <line index> <slot> <app id> <tag> <real page> <present>
# R <id> <virtual address> <len> <hit> <expected real page>
P 12345 0 1 0aa000 0bbbbb 1
P 12345 3 1 12345 0abcde 1
P 22222 0 1 22222 055555 0
P 33333 5 1 100033333 066666 1
P 44444 7 2 44444 077777 1
P 55555 1 1 55555 0a0001 1
P 55555 6 0 55555 0dead0 1
R 0011 12345678 00 1 0abcde
R 0022 22222abc 00 0 000000
R 0033 33333100 00 0 000000
R 0044 44444000 00 0 000000
R 0055 55555040 07 1 0a0001
R 0066 0001000012345000 00 0 000000
R 0077 12345800 03 1 0abcde
R 0088 22222000 00 0 000000
R 0099 55555000 0f 1 0a0001
R 00aa 33333fc0 02 0 000000
R 00bb 12345000 01 1 0abcde

// File: filelist.f
+incdir+design
design/tlb_pkg.sv
design/sync_fifo.sv
design/read_mgr.sv
design/pte_walker.sv
design/phys_read_mux.sv
design/axi_tlb_top.sv
verif/phys_mem_model.sv
verif/tb_axi_tlb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the TLB testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_axi_tlb -f filelist.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

grep -qx "=== PASS ===" sim.log
echo "simulation passed"
